// File: include/lms_frontend_macros.svh
// LMS6002D frontend widths shared by the package and the DSP core boundary
`ifndef LMS_FRONTEND_MACROS_SVH
`define LMS_FRONTEND_MACROS_SVH

// Sample bus on the LMS6002D pins, shared by ADC and DAC side
`define LMS_SAMPLE_W 12

// Receive word handed to the DSP core
// Wider than the LMS bus, upper bits stay zero
`define CORE_ADC_W 14

// Transmit word coming out of the DSP core
// Only the low LMS_SAMPLE_W bits reach the transceiver
`define CORE_DAC_W 16

// Upper ADC bits filled with zero on capture
`define CORE_ADC_PAD_W (`CORE_ADC_W - `LMS_SAMPLE_W)

`endif

// File: rtl/lms_frontend_pkg.sv
// LMS frontend package with sample word types and the IQ select encoding
package lms_frontend_pkg;

`include "lms_frontend_macros.svh"

   // One sample as it sits on an LMS bus
   typedef logic [`LMS_SAMPLE_W-1:0] lms_sample_t;

   // Receive word for the core, zero-extended sample
   typedef logic [`CORE_ADC_W-1:0] adc_word_t;

   // Transmit word from the core
   typedef logic [`CORE_DAC_W-1:0] dac_word_t;

   // Zero bits on top of a captured sample
   typedef logic [`CORE_ADC_PAD_W-1:0] adc_pad_t;

   // Meaning of every IQ select line, rx and tx alike
   typedef enum logic
   {
      IQ_SEL_I = 1'b0,   // I sample on the bus
      IQ_SEL_Q = 1'b1    // Q sample on the bus
   } iq_sel_e;

   // Widen a bus sample to a core ADC word
   function automatic adc_word_t widen_sample(input lms_sample_t sample);
      adc_pad_t pad;
      pad = '0;
      return {pad, sample};
   endfunction

endpackage

// File: rtl/lms_rx_capture.sv
// Receive capture, splits each interleaved LMS bus into held I and Q core words
module lms_rx_capture
(
   input  logic                        dsp_clk,
   input  logic                        rst_n_i,

   // Channel 1 LMS receive bus
   input  lms_frontend_pkg::iq_sel_e     rx1_iqsel_i,
   input  lms_frontend_pkg::lms_sample_t rx1_d_i,

   // Channel 2 LMS receive bus
   input  lms_frontend_pkg::iq_sel_e     rx2_iqsel_i,
   input  lms_frontend_pkg::lms_sample_t rx2_d_i,

   // Held words toward the core
   output lms_frontend_pkg::adc_word_t   adc_i1_o,
   output lms_frontend_pkg::adc_word_t   adc_q1_o,
   output lms_frontend_pkg::adc_word_t   adc_i2_o,
   output lms_frontend_pkg::adc_word_t   adc_q2_o
);

   import lms_frontend_pkg::*;

   adc_word_t rx1_word;   // Channel 1 sample, widened
   adc_word_t rx2_word;   // Channel 2 sample, widened

   // Upper bits come in as zero
   assign rx1_word = widen_sample(rx1_d_i);
   assign rx2_word = widen_sample(rx2_d_i);

   // Channel 1
   // IQ select steers the sample into one register, the other keeps its word
   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         adc_i1_o <= '0;
         adc_q1_o <= '0;
      end
      else if (rx1_iqsel_i == IQ_SEL_I)
      begin
         adc_i1_o <= rx1_word;   // I phase
      end
      else
      begin
         adc_q1_o <= rx1_word;   // Q phase
      end
   end

   // Channel 2, same split with its own select line
   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         adc_i2_o <= '0;
         adc_q2_o <= '0;
      end
      else if (rx2_iqsel_i == IQ_SEL_I)
      begin
         adc_i2_o <= rx2_word;   // I phase
      end
      else
      begin
         adc_q2_o <= rx2_word;   // Q phase
      end
   end

endmodule

// File: rtl/lms_tx_interleave.sv
// Transmit interleave, alternates core I and Q words onto both LMS transmit buses
module lms_tx_interleave
(
   input  logic                          dsp_clk,
   input  logic                          rst_n_i,

   // Core transmit words, channel 1
   input  lms_frontend_pkg::dac_word_t   dac_i1_i,
   input  lms_frontend_pkg::dac_word_t   dac_q1_i,

   // Core transmit words, channel 2
   input  lms_frontend_pkg::dac_word_t   dac_i2_i,
   input  lms_frontend_pkg::dac_word_t   dac_q2_i,

   // LMS transmit buses
   output lms_frontend_pkg::lms_sample_t tx1_d_o,
   output lms_frontend_pkg::iq_sel_e     tx1_iqsel_o,
   output lms_frontend_pkg::lms_sample_t tx2_d_o,
   output lms_frontend_pkg::iq_sel_e     tx2_iqsel_o
);

   import lms_frontend_pkg::*;

   iq_sel_e     phase_q;    // Shared phase, keeps both channels aligned
   iq_sel_e     phase_nxt;
   lms_sample_t tx1_word;   // Truncated word picked for this edge
   lms_sample_t tx2_word;

   // Phase flips every cycle, I first out of reset
   assign phase_nxt = (phase_q == IQ_SEL_I) ? IQ_SEL_Q : IQ_SEL_I;

   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         phase_q <= IQ_SEL_I;
      else
         phase_q <= phase_nxt;
   end

   // Word selection, low bits only go to the pins
   always_comb
   begin
      if (phase_q == IQ_SEL_I)
      begin
         tx1_word = lms_sample_t'(dac_i1_i);
         tx2_word = lms_sample_t'(dac_i2_i);
      end
      else
      begin
         tx1_word = lms_sample_t'(dac_q1_i);
         tx2_word = lms_sample_t'(dac_q2_i);
      end
   end

   // Output registers
   // Data and select loaded together so the pins never disagree
   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         tx1_d_o     <= '0;
         tx2_d_o     <= '0;
         tx1_iqsel_o <= IQ_SEL_I;
         tx2_iqsel_o <= IQ_SEL_I;
      end
      else
      begin
         tx1_d_o     <= tx1_word;
         tx2_d_o     <= tx2_word;
         tx1_iqsel_o <= phase_q;   // Same phase on both channels
         tx2_iqsel_o <= phase_q;
      end
   end

endmodule

// File: rtl/lms_frontend_top.sv
// LMS6002D frontend top, joins the receive capture and transmit interleave paths
module lms_frontend_top
(
   input  logic                          dsp_clk,
   input  logic                          rst_n_i,

   // Receive bus, transceiver 1
   input  lms_frontend_pkg::iq_sel_e     rx1_iqsel_i,
   input  lms_frontend_pkg::lms_sample_t rx1_d_i,

   // Receive bus, transceiver 2
   input  lms_frontend_pkg::iq_sel_e     rx2_iqsel_i,
   input  lms_frontend_pkg::lms_sample_t rx2_d_i,

   // Receive words toward the core
   output lms_frontend_pkg::adc_word_t   adc_i1_o,
   output lms_frontend_pkg::adc_word_t   adc_q1_o,
   output lms_frontend_pkg::adc_word_t   adc_i2_o,
   output lms_frontend_pkg::adc_word_t   adc_q2_o,

   // Transmit words from the core
   input  lms_frontend_pkg::dac_word_t   dac_i1_i,
   input  lms_frontend_pkg::dac_word_t   dac_q1_i,
   input  lms_frontend_pkg::dac_word_t   dac_i2_i,
   input  lms_frontend_pkg::dac_word_t   dac_q2_i,

   // Transmit bus, transceiver 1
   output lms_frontend_pkg::lms_sample_t tx1_d_o,
   output lms_frontend_pkg::iq_sel_e     tx1_iqsel_o,

   // Transmit bus, transceiver 2
   output lms_frontend_pkg::lms_sample_t tx2_d_o,
   output lms_frontend_pkg::iq_sel_e     tx2_iqsel_o
);

   import lms_frontend_pkg::*;

   // Receive side toward the core
   lms_rx_capture rx_capture
   (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .rx1_iqsel_i (rx1_iqsel_i),
      .rx1_d_i     (rx1_d_i),
      .rx2_iqsel_i (rx2_iqsel_i),
      .rx2_d_i     (rx2_d_i),
      .adc_i1_o    (adc_i1_o),
      .adc_q1_o    (adc_q1_o),
      .adc_i2_o    (adc_i2_o),
      .adc_q2_o    (adc_q2_o)
   );

   // Transmit side, registered on the rising edge like the rest
   lms_tx_interleave tx_interleave
   (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .dac_i1_i    (dac_i1_i),
      .dac_q1_i    (dac_q1_i),
      .dac_i2_i    (dac_i2_i),
      .dac_q2_i    (dac_q2_i),
      .tx1_d_o     (tx1_d_o),
      .tx1_iqsel_o (tx1_iqsel_o),
      .tx2_d_o     (tx2_d_o),
      .tx2_iqsel_o (tx2_iqsel_o)
   );

endmodule

// File: test/lms_frontend_checker.sv
// LMS frontend checker, assertions on the transmit phase and receive word padding
`include "lms_frontend_macros.svh"

module lms_frontend_checker
(
   input logic                        dsp_clk,
   input logic                        rst_n_i,
   input lms_frontend_pkg::iq_sel_e   tx1_iqsel_i,
   input lms_frontend_pkg::iq_sel_e   tx2_iqsel_i,
   input lms_frontend_pkg::adc_word_t adc_i1_i,
   input lms_frontend_pkg::adc_word_t adc_q1_i,
   input lms_frontend_pkg::adc_word_t adc_i2_i,
   input lms_frontend_pkg::adc_word_t adc_q2_i
);

   timeunit 1ns;
   timeprecision 1ps;

   import lms_frontend_pkg::*;

   int assert_fails = 0;   // Read by the testbench for its verdict

   // First edge out of reset repeats the I of the reset value
   tx_phase_toggles: assert property (
      @(posedge dsp_clk) disable iff (!rst_n_i)
      (rst_n_i && $past(rst_n_i) && $past(rst_n_i, 2)) |->
         (tx1_iqsel_i != $past(tx1_iqsel_i)))
      else
      begin
         $error("tx1_iqsel_o did not alternate");
         assert_fails++;
      end

   tx_phase_shared: assert property (
      @(posedge dsp_clk) tx1_iqsel_i == tx2_iqsel_i)
      else
      begin
         $error("tx1_iqsel_o and tx2_iqsel_o differ");
         assert_fails++;
      end

   // Padding above the 12-bit sample
   adc_upper_zero: assert property (
      @(posedge dsp_clk)
      ~|{adc_i1_i[`CORE_ADC_W-1:`LMS_SAMPLE_W], adc_q1_i[`CORE_ADC_W-1:`LMS_SAMPLE_W],
         adc_i2_i[`CORE_ADC_W-1:`LMS_SAMPLE_W], adc_q2_i[`CORE_ADC_W-1:`LMS_SAMPLE_W]})
      else
      begin
         $error("upper bits of an adc word are not zero");
         assert_fails++;
      end

endmodule

// File: test/lms_frontend_tb.sv
// LMS frontend testbench, random receive and transmit traffic against a reference model
`include "lms_frontend_macros.svh"

module lms_frontend_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import lms_frontend_pkg::*;

   localparam int CLK_PERIOD = 40;
   localparam int RUN_CYCLES = 200;

   logic        dsp_clk = 1'b0;
   logic        rst_n_i;
   iq_sel_e     rx1_iqsel_i;
   lms_sample_t rx1_d_i;
   iq_sel_e     rx2_iqsel_i;
   lms_sample_t rx2_d_i;
   adc_word_t   adc_i1_o;
   adc_word_t   adc_q1_o;
   adc_word_t   adc_i2_o;
   adc_word_t   adc_q2_o;
   dac_word_t   dac_i1_i;
   dac_word_t   dac_q1_i;
   dac_word_t   dac_i2_i;
   dac_word_t   dac_q2_i;
   lms_sample_t tx1_d_o;
   iq_sel_e     tx1_iqsel_o;
   lms_sample_t tx2_d_o;
   iq_sel_e     tx2_iqsel_o;

   // Reference model state
   adc_word_t   exp_adc_i1;
   adc_word_t   exp_adc_q1;
   adc_word_t   exp_adc_i2;
   adc_word_t   exp_adc_q2;
   lms_sample_t exp_tx1_d;
   lms_sample_t exp_tx2_d;
   iq_sel_e     exp_tx_iqsel;
   iq_sel_e     exp_phase;   // Phase used at the next edge

   logic [31:0] lfsr_state;
   int          edge_cnt = 0;
   int          err_cnt = 0;
   int          pass_tests = 0;
   int          fail_tests = 0;
   logic        timed_out = 1'b0;

   lms_frontend_top dut (.*);

   bind lms_frontend_top lms_frontend_checker frontend_checker
   (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .tx1_iqsel_i (tx1_iqsel_o),
      .tx2_iqsel_i (tx2_iqsel_o),
      .adc_i1_i    (adc_i1_o),
      .adc_q1_i    (adc_q1_o),
      .adc_i2_i    (adc_i2_o),
      .adc_q2_i    (adc_q2_o)
   );

   always #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;

   always @(posedge dsp_clk)
      edge_cnt <= edge_cnt + 1;   // Seen by the wait loop one step later

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] state);
      logic fb;
      fb = state[31] ^ state[21] ^ state[1] ^ state[0];
      return {state[30:0], fb};
   endfunction

   // One LFSR step per bit
   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] value;
      value = '0;
      for (int b = 0; b < n; b++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         value = {value[14:0], lfsr_state[0]};
      end
      return value;
   endfunction

   task automatic report_and_finish();
      int assert_fails;
      assert_fails = dut.frontend_checker.assert_fails;
      $display("tests passed %0d, tests failed %0d, check errors %0d, assertion failures %0d",
               pass_tests, fail_tests, err_cnt, assert_fails);
      if (fail_tests == 0 && err_cnt == 0 && assert_fails == 0 && !timed_out)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   endtask

   // Returns one time step after the n-th rising edge from now
   task automatic wait_edges(input int n, input string what);
      int target;
      int guard;
      target = edge_cnt + n;
      guard = 0;
      while (edge_cnt < target && guard <= n * CLK_PERIOD + 10)
      begin
         #1;
         guard++;
      end
      if (edge_cnt < target)
      begin
         $display("timeout, no clock edge arrived while waiting for %s", what);
         timed_out = 1'b1;
         report_and_finish();
      end
   endtask

   task automatic reset_model();
      exp_adc_i1   = '0;
      exp_adc_q1   = '0;
      exp_adc_i2   = '0;
      exp_adc_q2   = '0;
      exp_tx1_d    = '0;
      exp_tx2_d    = '0;
      exp_tx_iqsel = IQ_SEL_I;
      exp_phase    = IQ_SEL_I;   // First word after release is I
   endtask

   task automatic drive_inputs(input bit shared_iqsel);
      logic [15:0] bits;
      bits = take_bits(1);
      rx1_iqsel_i = bits[0] ? IQ_SEL_Q : IQ_SEL_I;
      if (shared_iqsel)
         rx2_iqsel_i = rx1_iqsel_i;
      else
      begin
         bits = take_bits(1);
         rx2_iqsel_i = bits[0] ? IQ_SEL_Q : IQ_SEL_I;
      end
      bits = take_bits(`LMS_SAMPLE_W);
      rx1_d_i = bits[`LMS_SAMPLE_W-1:0];
      bits = take_bits(`LMS_SAMPLE_W);
      rx2_d_i = bits[`LMS_SAMPLE_W-1:0];
      dac_i1_i = take_bits(`CORE_DAC_W);
      dac_q1_i = take_bits(`CORE_DAC_W);
      dac_i2_i = take_bits(`CORE_DAC_W);
      dac_q2_i = take_bits(`CORE_DAC_W);
   endtask

   // Expected outputs after the coming edge
   task automatic predict_edge();
      if (rx1_iqsel_i == IQ_SEL_I)
         exp_adc_i1 = {{(`CORE_ADC_W - `LMS_SAMPLE_W){1'b0}}, rx1_d_i};
      else
         exp_adc_q1 = {{(`CORE_ADC_W - `LMS_SAMPLE_W){1'b0}}, rx1_d_i};
      if (rx2_iqsel_i == IQ_SEL_I)
         exp_adc_i2 = {{(`CORE_ADC_W - `LMS_SAMPLE_W){1'b0}}, rx2_d_i};
      else
         exp_adc_q2 = {{(`CORE_ADC_W - `LMS_SAMPLE_W){1'b0}}, rx2_d_i};
      exp_tx1_d = (exp_phase == IQ_SEL_I) ? dac_i1_i[`LMS_SAMPLE_W-1:0]
                                          : dac_q1_i[`LMS_SAMPLE_W-1:0];
      exp_tx2_d = (exp_phase == IQ_SEL_I) ? dac_i2_i[`LMS_SAMPLE_W-1:0]
                                          : dac_q2_i[`LMS_SAMPLE_W-1:0];
      exp_tx_iqsel = exp_phase;
      exp_phase = (exp_phase == IQ_SEL_I) ? IQ_SEL_Q : IQ_SEL_I;
   endtask

   task automatic report_mismatch(input string name, input logic [15:0] expected,
                                  input logic [15:0] actual);
      $display("CHECK FAILED %s expected %h actual %h at %0t", name, expected, actual, $time);
      err_cnt++;
   endtask

   task automatic compare_outputs();
      if (adc_i1_o !== exp_adc_i1)
         report_mismatch("adc_i1_o", exp_adc_i1, adc_i1_o);
      if (adc_q1_o !== exp_adc_q1)
         report_mismatch("adc_q1_o", exp_adc_q1, adc_q1_o);
      if (adc_i2_o !== exp_adc_i2)
         report_mismatch("adc_i2_o", exp_adc_i2, adc_i2_o);
      if (adc_q2_o !== exp_adc_q2)
         report_mismatch("adc_q2_o", exp_adc_q2, adc_q2_o);
      if (tx1_d_o !== exp_tx1_d)
         report_mismatch("tx1_d_o", exp_tx1_d, tx1_d_o);
      if (tx2_d_o !== exp_tx2_d)
         report_mismatch("tx2_d_o", exp_tx2_d, tx2_d_o);
      if (tx1_iqsel_o !== exp_tx_iqsel)
         report_mismatch("tx1_iqsel_o", exp_tx_iqsel, tx1_iqsel_o);
      if (tx2_iqsel_o !== exp_tx_iqsel)
         report_mismatch("tx2_iqsel_o", exp_tx_iqsel, tx2_iqsel_o);
   endtask

   // Starts and ends two time steps after an edge
   task automatic run_cycle(input bit shared_iqsel);
      drive_inputs(shared_iqsel);
      predict_edge();
      wait_edges(1, "the next sample edge");
      compare_outputs();
      #1;
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (err_cnt == errs_before)
      begin
         $display("test %s done, no errors", name);
         pass_tests++;
      end
      else
      begin
         $display("test %s done, %0d errors", name, err_cnt - errs_before);
         fail_tests++;
      end
   endtask

   initial
   begin
      int errs;
      lfsr_state  = 32'hb551;
      rst_n_i     = 1'b0;
      rx1_iqsel_i = IQ_SEL_I;
      rx2_iqsel_i = IQ_SEL_I;
      rx1_d_i     = '0;
      rx2_d_i     = '0;
      dac_i1_i    = '0;
      dac_q1_i    = '0;
      dac_i2_i    = '0;
      dac_q2_i    = '0;
      reset_model();

      errs = err_cnt;
      wait_edges(1, "the first edge in reset");
      compare_outputs();
      wait_edges(2, "the end of the reset cycles");
      #1;
      rst_n_i = 1'b1;
      compare_outputs();   // Still the reset values
      end_test("reset values", errs);

      errs = err_cnt;
      for (int i = 0; i < RUN_CYCLES; i++)
         run_cycle(1'b1);
      end_test("receive split", errs);

      errs = err_cnt;
      for (int i = 0; i < RUN_CYCLES; i++)
         run_cycle(1'b0);
      end_test("channel independence", errs);

      errs = err_cnt;
      for (int i = 0; i < RUN_CYCLES; i++)
         run_cycle(1'b0);
      end_test("transmit interleave", errs);

      // Asynchronous reset in the middle of traffic
      errs = err_cnt;
      rst_n_i = 1'b0;
      reset_model();
      #1;
      compare_outputs();
      wait_edges(3, "the end of the mid-run reset");
      #1;
      rst_n_i = 1'b1;
      compare_outputs();
      for (int i = 0; i < 20; i++)
         run_cycle(1'b0);
      end_test("reset mid-run", errs);

      report_and_finish();
   end

endmodule

// File: all.f
+incdir+include
rtl/lms_frontend_pkg.sv
rtl/lms_rx_capture.sv
rtl/lms_tx_interleave.sv
rtl/lms_frontend_top.sv
test/lms_frontend_checker.sv
test/lms_frontend_tb.sv

// File: Bender.yml
package:
  name: lms_frontend

export_include_dirs:
  - include

sources:
  - files:
      - rtl/lms_frontend_pkg.sv
      - rtl/lms_rx_capture.sv
      - rtl/lms_tx_interleave.sv
      - rtl/lms_frontend_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/lms_frontend_checker.sv
      - test/lms_frontend_tb.sv
